/* wb_macros.svh */
//////////////////////////////
// Global sizes for the writeback subsystem
// WB_XLEN must stay 32; the load aligner
// assumes four byte lanes per word
// WB_NREGS counts x0, which has no storage
//////////////////////////////
`ifndef WB_MACROS_SVH
`define WB_MACROS_SVH

// Data path width
`define WB_XLEN 32

// Architectural registers, x0 included
`define WB_NREGS 32

// Width of each retirement counter
// Counters wrap silently at this width
`define WB_CNT_W 16

`endif

/* wb_pkg.sv */
//////////////////////////////
// Types shared by the writeback subsystem
// Sizes come from wb_macros.svh
// Loads and coprocessor items are
// assumed mutually exclusive in one item
//////////////////////////////
`include "wb_macros.svh"

package wb_pkg;

  // Register index, x0 to x31
  typedef logic [4:0] rf_addr_t;

  // Load access size
  typedef enum logic [1:0] {
    LS_BYTE = 2'b00,
    LS_HALF = 2'b01,
    LS_WORD = 2'b10
  } ls_size_e;

  //////////////////////////////
  // EX/WB pipe payload
  //////////////////////////////
  typedef struct packed {
    logic                rf_we;
    rf_addr_t            rf_waddr;
    // ALU result
    logic [`WB_XLEN-1:0] rf_wdata;
    logic                lsu_en;
    ls_size_e            lsu_size;
    logic                lsu_signed;
    // Byte offset of the load address
    logic [1:0]          lsu_offset;
    logic                xif_en;
  } ex_wb_pipe_t;

  // Load response, err is a protection fault
  typedef struct packed {
    logic [`WB_XLEN-1:0] rdata;
    logic                err;
  } lsu_resp_t;

  // Coprocessor result, held by the source until consumed
  typedef struct packed {
    logic                valid;
    logic [`WB_XLEN-1:0] data;
    logic                exc;
  } xif_result_t;

  // Controller requests towards WB
  typedef struct packed {
    logic kill_wb;
    logic halt_wb;
  } ctrl_wb_t;

  // Counter readout
  typedef struct packed {
    logic [`WB_CNT_W-1:0] retired;
    logic [`WB_CNT_W-1:0] excepted;
  } retire_cnt_t;

endpackage

/* wb_pipe_reg.sv */
//////////////////////////////
// Single entry valid/ready register
// Holds one payload; refills in the same
// cycle the downstream side drains it
// Ready stays low for one cycle after reset
// Payload has no reset, only the flags do
//////////////////////////////
`timescale 1ns/1ps

module wb_pipe_reg import wb_pkg::*; #(
  parameter type payload_t = ex_wb_pipe_t
) (
  input  logic     clk,
  input  logic     rst_n_i,

  // Upstream side
  input  logic     valid_i,
  input  payload_t payload_i,
  output logic     ready_o,

  // Downstream side
  output logic     valid_o,
  output payload_t payload_o,
  input  logic     ready_i
);

  logic     valid_q;
  logic     en_q;
  logic     load;
  payload_t payload_q;

  // Accept when empty or when the current entry leaves
  assign ready_o = en_q && (!valid_q || ready_i);
  assign load    = valid_i && ready_o;

  // Control flags
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q    <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      en_q <= 1'b1;
      if (load) begin
        valid_q <= 1'b1;
      end else if (ready_i) begin
        // Entry drained with nothing new behind it
        valid_q <= 1'b0;
      end
    end
  end

  // Payload capture
  always_ff @(posedge clk) begin
    if (load) begin
      payload_q <= payload_i;
    end
  end

  assign valid_o   = valid_q;
  assign payload_o = payload_q;

endmodule

/* wb_load_align.sv */
//////////////////////////////
// Load data formatting
// Aligned accesses only; a word load
// with a nonzero offset returns the
// shifted word without wrap-around
//////////////////////////////
`timescale 1ns/1ps
`include "wb_macros.svh"

module wb_load_align import wb_pkg::*; (
  input  logic [`WB_XLEN-1:0] rdata_i,
  input  ls_size_e            size_i,
  input  logic                signed_i,
  input  logic [1:0]          offset_i,
  output logic [`WB_XLEN-1:0] data_o
);

  logic [`WB_XLEN-1:0] shifted;
  logic                fill_b;
  logic                fill_h;

  // Move the addressed byte lane down to bit 0
  assign shifted = rdata_i >> {offset_i, 3'b000};

  // Sign bits for the narrow sizes
  assign fill_b = signed_i & shifted[7];
  assign fill_h = signed_i & shifted[15];

  //////////////////////////////
  // Size selection
  //////////////////////////////
  always_comb begin
    case (size_i)
      LS_BYTE: begin
        data_o = {{(`WB_XLEN-8){fill_b}}, shifted[7:0]};
      end
      LS_HALF: begin
        data_o = {{(`WB_XLEN-16){fill_h}}, shifted[15:0]};
      end
      default: begin
        // Full word, nothing to extend
        data_o = shifted;
      end
    endcase
  end

endmodule

/* wb_stage.sv */
//////////////////////////////
// Writeback stage, purely combinational
// Every item is its own last operation
// The controller must not halt or kill a
// load while its response is in flight
// Load and coprocessor flags never both set
//////////////////////////////
`timescale 1ns/1ps
`include "wb_macros.svh"

module wb_stage import wb_pkg::*; (
  // EX/WB pipe item
  input  logic                pipe_valid_i,
  input  ex_wb_pipe_t         pipe_i,

  // Registered LSU response, formatted data
  input  logic [`WB_XLEN-1:0] load_data_i,
  input  logic                lsu_valid_i,
  input  logic                lsu_err_i,

  // Coprocessor result
  input  xif_result_t         xif_result_i,
  output logic                xif_result_ready_o,

  // Controller
  input  ctrl_wb_t            ctrl_i,

  // Register file write port
  output logic                rf_we_o,
  output rf_addr_t            rf_waddr_o,
  output logic [`WB_XLEN-1:0] rf_wdata_o,

  // Stage handshake and status
  output logic                wb_ready_o,
  output logic                wb_valid_o,
  output logic                exc_o,
  output logic                data_stall_o
);

  logic live;
  logic done;
  logic waiting;
  logic lsu_exc;
  logic xif_exc;
  logic exc;

  // Valid and neither killed nor halted
  assign live = pipe_valid_i && !ctrl_i.kill_wb && !ctrl_i.halt_wb;

  //////////////////////////////
  // Completion
  //////////////////////////////
  // ALU items finish on arrival
  assign done = pipe_i.lsu_en ? lsu_valid_i :
                pipe_i.xif_en ? xif_result_i.valid :
                1'b1;

  // Item present but result not there yet
  assign waiting = pipe_valid_i && !done;

  // Faults only count with their own response
  assign lsu_exc = pipe_i.lsu_en && lsu_valid_i && lsu_err_i;
  assign xif_exc = pipe_i.xif_en && xif_result_i.valid && xif_result_i.exc;
  assign exc     = lsu_exc || xif_exc;

  //////////////////////////////
  // Register file write
  //////////////////////////////
  assign rf_we_o    = wb_valid_o && pipe_i.rf_we && !exc;
  assign rf_waddr_o = pipe_i.rf_waddr;
  assign rf_wdata_o = pipe_i.lsu_en ? load_data_i :
                      pipe_i.xif_en ? xif_result_i.data :
                      pipe_i.rf_wdata;

  // Retire, exceptional items included
  assign wb_valid_o = live && done;
  assign exc_o      = wb_valid_o && exc;

  // Kill always frees the stage
  assign wb_ready_o = ctrl_i.kill_wb || (!ctrl_i.halt_wb && !waiting);

  // Result taken only when it can retire or be dropped
  assign xif_result_ready_o = pipe_valid_i && pipe_i.xif_en && !ctrl_i.halt_wb;

  // Live load with no response yet
  assign data_stall_o = live && pipe_i.lsu_en && !lsu_valid_i;

endmodule

/* wb_regfile.sv */
//////////////////////////////
// Integer register file
// One write port, two combinational reads
// Writes show on the read ports after
// the clock edge, no write-through bypass
//////////////////////////////
`timescale 1ns/1ps
`include "wb_macros.svh"

module wb_regfile import wb_pkg::*; (
  input  logic                clk,
  input  logic                rst_n_i,

  // Write port
  input  logic                we_i,
  input  rf_addr_t            waddr_i,
  input  logic [`WB_XLEN-1:0] wdata_i,

  // Read ports
  input  rf_addr_t            raddr_a_i,
  output logic [`WB_XLEN-1:0] rdata_a_o,
  input  rf_addr_t            raddr_b_i,
  output logic [`WB_XLEN-1:0] rdata_b_o
);

  // Storage for x1 to x31 only
  logic [`WB_XLEN-1:0] regs_q [1:`WB_NREGS-1];

  //////////////////////////////
  // Write
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < `WB_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      // x0 writes fall through here
      regs_q[waddr_i] <= wdata_i;
    end
  end

  //////////////////////////////
  // Read
  //////////////////////////////
  // x0 is hardwired to zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* wb_retire_cnt.sv */
//////////////////////////////
// Retirement counters
// Both counters wrap at WB_CNT_W bits
// Clear wins over a same-cycle strobe
//////////////////////////////
`timescale 1ns/1ps
`include "wb_macros.svh"

module wb_retire_cnt import wb_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,

  // Strobes from the stage
  input  logic        retire_i,
  input  logic        exc_i,

  // Synchronous clear
  input  logic        clear_i,

  output retire_cnt_t cnt_o
);

  retire_cnt_t cnt_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (clear_i) begin
      cnt_q <= '0;
    end else begin
      // Every completed item, exceptional or not
      if (retire_i) begin
        cnt_q.retired <= cnt_q.retired + 1'b1;
      end
      // Suppressed writes only
      if (exc_i) begin
        cnt_q.excepted <= cnt_q.excepted + 1'b1;
      end
    end
  end

  // Readout straight from the flops
  assign cnt_o = cnt_q;

endmodule

/* wb_subsys_top.sv */
//////////////////////////////
// Writeback subsystem top level
// EX source must hold its inputs while
// ex_ready_o is low
// LSU response is a one-cycle strobe
// with no back-pressure
//////////////////////////////
`timescale 1ns/1ps
`include "wb_macros.svh"

module wb_subsys_top import wb_pkg::*; (
  input  logic                clk,
  input  logic                rst_n_i,

  // Execute side
  input  logic                ex_valid_i,
  input  ex_wb_pipe_t         ex_pipe_i,
  output logic                ex_ready_o,

  // Load/store unit response
  input  logic                lsu_rvalid_i,
  input  lsu_resp_t           lsu_resp_i,

  // Coprocessor
  input  xif_result_t         xif_result_i,
  output logic                xif_result_ready_o,

  // Controller
  input  logic                kill_wb_i,
  input  logic                halt_wb_i,

  // Register read ports
  input  rf_addr_t            rs1_addr_i,
  output logic [`WB_XLEN-1:0] rs1_rdata_o,
  input  rf_addr_t            rs2_addr_i,
  output logic [`WB_XLEN-1:0] rs2_rdata_o,

  // Status
  output logic                wb_valid_o,
  output logic                data_stall_o,

  // Counters
  input  logic                cnt_clear_i,
  output retire_cnt_t         cnt_o
);

  //////////////////////////////
  // Internal wires
  //////////////////////////////
  logic                wb_pipe_valid;
  ex_wb_pipe_t         wb_pipe;
  logic                wb_ready;
  logic                lsu_valid;
  lsu_resp_t           lsu_resp;
  logic [`WB_XLEN-1:0] load_data;
  ctrl_wb_t            ctrl;
  logic                rf_we;
  rf_addr_t            rf_waddr;
  logic [`WB_XLEN-1:0] rf_wdata;
  logic                wb_exc;

  // Controller requests as one bundle
  assign ctrl.kill_wb = kill_wb_i;
  assign ctrl.halt_wb = halt_wb_i;

  // EX/WB pipe register
  wb_pipe_reg #(.payload_t(ex_wb_pipe_t)) u_ex_wb_pipe (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .valid_i   (ex_valid_i),
    .payload_i (ex_pipe_i),
    .ready_o   (ex_ready_o),
    .valid_o   (wb_pipe_valid),
    .payload_o (wb_pipe),
    .ready_i   (wb_ready)
  );

  // LSU response register, WB always takes it
  wb_pipe_reg #(.payload_t(lsu_resp_t)) u_lsu_resp (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .valid_i   (lsu_rvalid_i),
    .payload_i (lsu_resp_i),
    .ready_o   (),
    .valid_o   (lsu_valid),
    .payload_o (lsu_resp),
    .ready_i   (1'b1)
  );

  // Format uses the access info of the WB item
  wb_load_align u_load_align (
    .rdata_i  (lsu_resp.rdata),
    .size_i   (wb_pipe.lsu_size),
    .signed_i (wb_pipe.lsu_signed),
    .offset_i (wb_pipe.lsu_offset),
    .data_o   (load_data)
  );

  wb_stage u_wb_stage (
    .pipe_valid_i       (wb_pipe_valid),
    .pipe_i             (wb_pipe),
    .load_data_i        (load_data),
    .lsu_valid_i        (lsu_valid),
    .lsu_err_i          (lsu_resp.err),
    .xif_result_i       (xif_result_i),
    .xif_result_ready_o (xif_result_ready_o),
    .ctrl_i             (ctrl),
    .rf_we_o            (rf_we),
    .rf_waddr_o         (rf_waddr),
    .rf_wdata_o         (rf_wdata),
    .wb_ready_o         (wb_ready),
    .wb_valid_o         (wb_valid_o),
    .exc_o              (wb_exc),
    .data_stall_o       (data_stall_o)
  );

  wb_regfile u_regfile (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata),
    .raddr_a_i (rs1_addr_i),
    .rdata_a_o (rs1_rdata_o),
    .raddr_b_i (rs2_addr_i),
    .rdata_b_o (rs2_rdata_o)
  );

  // Retire strobe is the stage valid
  wb_retire_cnt u_retire_cnt (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .retire_i (wb_valid_o),
    .exc_i    (wb_exc),
    .clear_i  (cnt_clear_i),
    .cnt_o    (cnt_o)
  );

endmodule

/* tb_wb_subsys.sv */
//////////////////////////////
// Testbench for the writeback subsystem
// Inputs change 10 ns after the rising edge,
// outputs are sampled on the falling edge
// Loads are never halted or killed in flight
// Every wait loop gives up after TMO cycles
//////////////////////////////
`timescale 1ns/1ps
`include "wb_macros.svh"

module tb_wb_subsys import wb_pkg::*; ();

  localparam int TMO = 50;

  logic                clk;
  logic                rst_n_i;
  logic                ex_valid_i;
  ex_wb_pipe_t         ex_pipe_i;
  logic                ex_ready_o;
  logic                lsu_rvalid_i;
  lsu_resp_t           lsu_resp_i;
  xif_result_t         xif_result_i;
  logic                xif_result_ready_o;
  logic                kill_wb_i;
  logic                halt_wb_i;
  rf_addr_t            rs1_addr_i;
  rf_addr_t            rs2_addr_i;
  logic [`WB_XLEN-1:0] rs1_rdata_o;
  logic [`WB_XLEN-1:0] rs2_rdata_o;
  logic                wb_valid_o;
  logic                data_stall_o;
  logic                cnt_clear_i;
  retire_cnt_t         cnt_o;

  // Expected register contents
  logic [`WB_XLEN-1:0] ref_regs [`WB_NREGS];
  logic [31:0]         rng;
  // Expected counter values since the last clear
  int                  exp_retired;
  int                  exp_excepted;
  // Destination of the current load
  rf_addr_t            ld_rd;
  int                  errors;
  int                  checks;
  int                  tests;
  int                  failed;
  int                  test_err0;

  wb_subsys_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic rf_addr_t rand_reg();
    logic [31:0] r;
    r = next_rand();
    return r[4:0];
  endfunction

  function void flag_error(string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endfunction

  function void check_value(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endfunction

  function void check_bit(string name, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endfunction

  // x0 never changes
  function void model_write(rf_addr_t rd, logic [31:0] val);
    if (rd != '0) begin
      ref_regs[rd] = val;
    end
  endfunction

  // Byte lanes above the offset move down, missing lanes read zero
  function automatic logic [31:0] expect_load(logic [31:0] rdata, ls_size_e size,
                                               logic sgn, logic [1:0] off);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < 4; i++) begin
      if (i + int'(off) < 4) begin
        v[8*i +: 8] = rdata[8*(i + int'(off)) +: 8];
      end
    end
    if (size == LS_BYTE) begin
      v = {{24{sgn & v[7]}}, v[7:0]};
    end else if (size == LS_HALF) begin
      v = {{16{sgn & v[15]}}, v[15:0]};
    end
    return v;
  endfunction

  function automatic ex_wb_pipe_t alu_item(rf_addr_t rd, logic [31:0] val);
    ex_wb_pipe_t it;
    it          = '0;
    it.rf_we    = 1'b1;
    it.rf_waddr = rd;
    it.rf_wdata = val;
    return it;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  //////////////////////////////
  // Handshake tasks
  //////////////////////////////
  // Offer one item and hold it until the pipe register takes it
  task automatic send_item(input ex_wb_pipe_t item);
    int   n;
    logic acc;
    n          = 0;
    acc        = 1'b0;
    ex_valid_i = 1'b1;
    ex_pipe_i  = item;
    while (!acc && n < TMO) begin
      @(negedge clk);
      acc = ex_ready_o;
      next_cycle();
      n++;
    end
    ex_valid_i = 1'b0;
    if (!acc) flag_error("ex_ready_o never rose, item not accepted");
  endtask

  task automatic wait_retire();
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < TMO) begin
      @(negedge clk);
      seen = wb_valid_o;
      next_cycle();
      n++;
    end
    if (!seen) flag_error("wb_valid_o never rose, item did not retire");
  endtask

  task automatic wait_ex_stall();
    int   n;
    logic low;
    n   = 0;
    low = 1'b0;
    while (!low && n < TMO) begin
      @(negedge clk);
      low = !ex_ready_o;
      next_cycle();
      n++;
    end
    if (!low) flag_error("ex_ready_o stayed high behind a waiting item");
  endtask

  task automatic run_alu(input rf_addr_t rd, input logic [31:0] val);
    send_item(alu_item(rd, val));
    wait_retire();
    model_write(rd, val);
    exp_retired++;
  endtask

  task automatic run_load(input rf_addr_t rd, input ls_size_e size, input logic sgn,
                          input logic [1:0] off, input logic [31:0] rdata, input logic err);
    ex_wb_pipe_t it;
    // ALU value rides along but is not selected
    it            = alu_item(rd, next_rand());
    it.lsu_en     = 1'b1;
    it.lsu_size   = size;
    it.lsu_signed = sgn;
    it.lsu_offset = off;
    send_item(it);
    // Load sits in WB with no response yet
    @(negedge clk);
    check_bit("data_stall_o", 1'b1, data_stall_o);
    next_cycle();
    repeat (next_rand() % 3) next_cycle();
    lsu_rvalid_i     = 1'b1;
    lsu_resp_i.rdata = rdata;
    lsu_resp_i.err   = err;
    next_cycle();
    lsu_rvalid_i = 1'b0;
    wait_retire();
    exp_retired++;
    if (err) begin
      exp_excepted++;
    end else begin
      model_write(rd, expect_load(rdata, size, sgn, off));
    end
  endtask

  // Coprocessor item with an ALU item queued behind it
  task automatic run_xif(input rf_addr_t rd, input logic [31:0] data, input logic exc);
    ex_wb_pipe_t it;
    ex_wb_pipe_t nxt;
    it        = alu_item(rd, next_rand());
    it.xif_en = 1'b1;
    nxt       = alu_item(rand_reg(), next_rand());
    send_item(it);
    ex_valid_i = 1'b1;
    ex_pipe_i  = nxt;
    wait_ex_stall();
    repeat (2) next_cycle();
    xif_result_i.valid = 1'b1;
    xif_result_i.data  = data;
    xif_result_i.exc   = exc;
    // Result taken and next item accepted on the same edge
    @(negedge clk);
    check_bit("xif_result_ready_o", 1'b1, xif_result_ready_o);
    check_bit("wb_valid_o", 1'b1, wb_valid_o);
    check_bit("ex_ready_o", 1'b1, ex_ready_o);
    next_cycle();
    xif_result_i = '0;
    ex_valid_i   = 1'b0;
    if (!exc) model_write(rd, data);
    if (exc) exp_excepted++;
    wait_retire();
    model_write(nxt.rf_waddr, nxt.rf_wdata);
    // Coprocessor item and the ALU item behind it
    exp_retired = exp_retired + 2;
  endtask

  task automatic run_killed(input rf_addr_t rd);
    send_item(alu_item(rd, next_rand()));
    kill_wb_i = 1'b1;
    next_cycle();
    kill_wb_i = 1'b0;
    repeat (2) next_cycle();
  endtask

  task automatic check_reg(input rf_addr_t idx);
    rs1_addr_i = idx;
    rs2_addr_i = idx;
    @(negedge clk);
    check_value($sformatf("rs1_rdata_o[x%0d]", idx), ref_regs[idx], rs1_rdata_o);
    check_value($sformatf("rs2_rdata_o[x%0d]", idx), ref_regs[idx], rs2_rdata_o);
    next_cycle();
  endtask

  task automatic check_all_regs();
    for (int i = 0; i < `WB_NREGS; i++) begin
      check_reg(rf_addr_t'(i));
    end
  endtask

  task automatic check_counts(input logic [31:0] ret, input logic [31:0] exc);
    check_value("cnt_o.retired", ret, 32'(cnt_o.retired));
    check_value("cnt_o.excepted", exc, 32'(cnt_o.excepted));
  endtask

  task automatic clear_counts();
    cnt_clear_i = 1'b1;
    next_cycle();
    cnt_clear_i  = 1'b0;
    exp_retired  = 0;
    exp_excepted = 0;
  endtask

  function void end_test(string name);
    tests++;
    if (errors == test_err0) begin
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: %0d errors", name, errors - test_err0);
    end
    test_err0 = errors;
  endfunction

  //////////////////////////////
  // Assertions
  //////////////////////////////
  // ALU item retires one cycle after acceptance
  assert property (@(posedge clk) disable iff (!rst_n_i)
    ex_valid_i && ex_ready_o && !ex_pipe_i.lsu_en && !ex_pipe_i.xif_en
    |=> wb_valid_o || halt_wb_i || kill_wb_i)
    else flag_error("ALU item did not retire one cycle after acceptance");

  // Stall holds until the response strobe
  assert property (@(posedge clk) disable iff (!rst_n_i)
    data_stall_o && !lsu_rvalid_i |=> data_stall_o)
    else flag_error("data_stall_o dropped before the load response");

  assert property (@(posedge clk) disable iff (!rst_n_i)
    data_stall_o && lsu_rvalid_i |=> !data_stall_o && wb_valid_o)
    else flag_error("load did not complete the cycle after its response");

  assert property (@(posedge clk) disable iff (!rst_n_i)
    xif_result_ready_o && !xif_result_i.valid |=> xif_result_ready_o)
    else flag_error("xif_result_ready_o fell with no result consumed");

  assert property (@(posedge clk) disable iff (!rst_n_i)
    halt_wb_i || kill_wb_i |-> !wb_valid_o)
    else flag_error("item retired while halted or killed");

  assert property (@(posedge clk) disable iff (!rst_n_i)
    cnt_clear_i |=> cnt_o == '0)
    else flag_error("counters not zero after clear");

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    rst_n_i      = 1'b0;
    ex_valid_i   = 1'b0;
    ex_pipe_i    = '0;
    lsu_rvalid_i = 1'b0;
    lsu_resp_i   = '0;
    xif_result_i = '0;
    kill_wb_i    = 1'b0;
    halt_wb_i    = 1'b0;
    rs1_addr_i   = '0;
    rs2_addr_i   = '0;
    cnt_clear_i  = 1'b0;
    rng          = 32'h69fd;
    exp_retired  = 0;
    exp_excepted = 0;
    ld_rd        = '0;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    failed       = 0;
    test_err0    = 0;
    for (int i = 0; i < `WB_NREGS; i++) begin
      ref_regs[i] = '0;
    end

    // Reset over three cycles, outputs checked inside it
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_bit("ex_ready_o", 1'b0, ex_ready_o);
    check_bit("wb_valid_o", 1'b0, wb_valid_o);
    check_bit("xif_result_ready_o", 1'b0, xif_result_ready_o);
    check_bit("data_stall_o", 1'b0, data_stall_o);
    check_counts(0, 0);
    next_cycle();
    rst_n_i = 1'b1;
    next_cycle();
    check_all_regs();
    end_test("reset");

    // Random ALU series, x0 write included
    repeat (40) run_alu(rand_reg(), next_rand());
    run_alu(5'd0, next_rand());
    check_all_regs();
    end_test("alu_writeback");

    for (int s = 0; s < 3; s++) begin
      for (int g = 0; g < 2; g++) begin
        for (int o = 0; o < 4; o++) begin
          ld_rd = rand_reg() | 5'd1;
          run_load(ld_rd, ls_size_e'(s), g[0], o[1:0], next_rand(), 1'b0);
          check_reg(ld_rd);
        end
      end
    end
    end_test("load_format");

    run_load(5'd7, LS_WORD, 1'b0, 2'd0, next_rand(), 1'b1);
    check_reg(5'd7);
    check_counts(exp_retired, exp_excepted);
    end_test("load_error");

    run_xif(5'd9, next_rand(), 1'b0);
    check_reg(5'd9);
    run_xif(5'd10, next_rand(), 1'b1);
    check_reg(5'd10);
    check_counts(exp_retired, exp_excepted);
    end_test("coprocessor");

    // Halt holds the item, kill drops it
    send_item(alu_item(5'd12, 32'h1234_5678));
    halt_wb_i = 1'b1;
    repeat (3) check_reg(5'd12);
    halt_wb_i = 1'b0;
    wait_retire();
    model_write(5'd12, 32'h1234_5678);
    exp_retired++;
    check_reg(5'd12);
    run_killed(5'd12);
    check_reg(5'd12);
    check_counts(exp_retired, exp_excepted);
    end_test("kill_halt");

    // Five ALU, one killed, one faulting load, coprocessor pair
    clear_counts();
    repeat (5) run_alu(rand_reg(), next_rand());
    run_killed(rand_reg());
    run_load(rand_reg(), LS_WORD, 1'b0, 2'd0, next_rand(), 1'b1);
    run_xif(rand_reg(), next_rand(), 1'b0);
    check_counts(8, 1);
    clear_counts();
    @(negedge clk);
    check_counts(0, 0);
    next_cycle();
    check_all_regs();
    end_test("counters");

    $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
             tests, failed, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* wb_subsys_top.f */
+incdir+.
wb_pkg.sv
wb_pipe_reg.sv
wb_load_align.sv
wb_stage.sv
wb_regfile.sv
wb_retire_cnt.sv
wb_subsys_top.sv
tb_wb_subsys.sv
